/* Makefile */
VERILATOR ?= verilator
TOP       := tb_sata_dma
FILELIST  := sources.f
BUILD     := obj_dir
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* include/dma_settings.svh */
// dma engine settings
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// data path widths
`define HOST_DW 32              // host port dword
`define MEM_DW 64               // memory word, two dwords
`define REG_AW 3                // register offset
`define REG_DW 32               // register data
`define CNT_W 8                 // sector count field

// sector geometry
`define DWORDS_PER_SECTOR 128   // 512-byte sector
`define ADDR_SHIFT 7            // memory address in 128-byte units

// register map
`define REG_ADDR 3'd0           // memory address, units
`define REG_LBA 3'd1            // disk lba
`define REG_COUNT 3'd2          // sector count
`define REG_CTRL 3'd3           // dir and start
`define REG_STATUS 3'd4         // busy and done, read only

// control register bits
`define CTRL_DIR_BIT 0          // 0 dev to mem, 1 mem to dev
`define CTRL_START_BIT 1        // self clearing

// status register bits
`define STAT_BUSY_BIT 0
`define STAT_DONE_BIT 1         // sticky until next start

`endif

/* source/dma_control.sv */
// dma transfer sequencer
`default_nettype none

`include "dma_settings.svh"

module dma_control (
    input  wire                     hclk,
    input  wire                     rst_n,
    input  wire dma_pkg::xfer_cfg_t cfg,
    input  wire                     start,
    output logic                    busy,
    output logic                    finish,
    output dma_pkg::host_cmd_t      host_cmd,
    output logic                    host_cmd_valid,
    input  wire                     host_cmd_ready,
    output dma_pkg::mem_cmd_t       mem_cmd,
    output logic                    mem_cmd_valid,
    input  wire                     mem_cmd_ready,
    output logic                    rx_en,
    output logic                    rd_en,
    input  wire                     mem_wr_fire,
    input  wire                     host_tx_fire
);
    import dma_pkg::*;

    localparam int XW = `CNT_W + 7;  // wide enough for count x 128 dwords
    localparam logic [XW-1:0] DW_PER_SECTOR = XW'(`DWORDS_PER_SECTOR);
    localparam logic [XW-1:0] WD_PER_SECTOR = XW'(`DWORDS_PER_SECTOR * `HOST_DW / `MEM_DW);

    ctl_state_t        state;
    xfer_cfg_t         cfg_q;       // snapshot taken at start
    logic [XW-1:0]     beat_q;      // far-end handshakes so far
    logic [XW-1:0]     count_ext;
    logic [XW-1:0]     host_total;  // dwords on host_tx
    logic [XW-1:0]     mem_total;   // words on mem_wr
    logic [XW-1:0]     total;
    logic              dev_to_mem;
    logic              beat_fire;
    logic              beat_last;
    logic              host_ok;
    logic              mem_ok;

    assign count_ext  = XW'(cfg_q.count);
    assign host_total = count_ext * DW_PER_SECTOR;
    assign mem_total  = count_ext * WD_PER_SECTOR;
    assign dev_to_mem = (cfg_q.dir == DIR_DEV_TO_MEM);
    assign total      = dev_to_mem ? mem_total : host_total;

    // count at the far end of whichever path is active
    assign beat_fire = dev_to_mem ? mem_wr_fire : host_tx_fire;
    assign beat_last = (beat_q == total - 1'b1);

    // command accepted now or earlier
    assign host_ok = ~host_cmd_valid | host_cmd_ready;
    assign mem_ok  = ~mem_cmd_valid | mem_cmd_ready;

    assign host_cmd.dir   = cfg_q.dir;
    assign host_cmd.lba   = cfg_q.lba;
    assign host_cmd.count = cfg_q.count;
    assign mem_cmd.dir    = cfg_q.dir;
    assign mem_cmd.addr   = cfg_q.addr;
    assign mem_cmd.words  = mem_total[XW-2:0];

    assign busy   = (state != CTL_IDLE);
    assign finish = (state == CTL_DONE);
    assign rx_en  = (state == CTL_XFER) & dev_to_mem;
    assign rd_en  = (state == CTL_XFER) & ~dev_to_mem;

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            state          <= CTL_IDLE;
            host_cmd_valid <= 1'b0;
            mem_cmd_valid  <= 1'b0;
            beat_q         <= '0;
        end else begin
            case (state)
                CTL_IDLE: begin
                    if (start) begin
                        state          <= CTL_ISSUE;
                        host_cmd_valid <= 1'b1;  // both rise together
                        mem_cmd_valid  <= 1'b1;
                        beat_q         <= '0;
                    end
                end
                CTL_ISSUE: begin
                    if (host_cmd_ready)
                        host_cmd_valid <= 1'b0;
                    if (mem_cmd_ready)
                        mem_cmd_valid <= 1'b0;
                    if (host_ok && mem_ok)
                        state <= (total == '0) ? CTL_DONE : CTL_XFER; // zero sectors, no data
                end
                CTL_XFER: begin
                    if (beat_fire) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_last)
                            state <= CTL_DONE;
                    end
                end
                CTL_DONE: state <= CTL_IDLE;         // finish seen by regs here
                default:  state <= CTL_IDLE;
            endcase
        end
    end

    always_ff @(posedge hclk) begin
        if (state == CTL_IDLE && start)
            cfg_q <= cfg;
    end

endmodule

`default_nettype wire

/* source/dma_pkg.sv */
// dma engine shared types
`default_nettype none

`include "dma_settings.svh"

package dma_pkg;

    // transfer direction, matches control register bit
    typedef enum logic {
        DIR_DEV_TO_MEM = 1'b0,  // host_rx -> pack -> mem_wr
        DIR_MEM_TO_DEV = 1'b1   // mem_rd -> unpack -> host_tx
    } dma_dir_t;

    // transfer sequencer
    typedef enum logic [1:0] {
        CTL_IDLE,               // waiting for start
        CTL_ISSUE,              // both commands outstanding
        CTL_XFER,               // data moving
        CTL_DONE                // finish pulse
    } ctl_state_t;

    // register bus request
    typedef struct packed {
        logic                write;     // 1 write, 0 read
        logic [`REG_AW-1:0]  offset;
        logic [`REG_DW-1:0]  wdata;
    } reg_req_t;

    // command to the disk host side
    typedef struct packed {
        dma_dir_t            dir;
        logic [`REG_DW-1:0]  lba;
        logic [`CNT_W-1:0]   count;     // sectors
    } host_cmd_t;

    // command to the memory side
    typedef struct packed {
        dma_dir_t                         dir;
        logic [`REG_DW-`ADDR_SHIFT-1:0]   addr;   // 128-byte units
        logic [`CNT_W+5:0]                words;  // 64-bit words, count x 64
    } mem_cmd_t;

    // register values latched by the sequencer at start
    typedef struct packed {
        dma_dir_t                         dir;
        logic [`REG_DW-`ADDR_SHIFT-1:0]   addr;
        logic [`REG_DW-1:0]               lba;
        logic [`CNT_W-1:0]                count;
    } xfer_cfg_t;

endpackage

`default_nettype wire

/* source/dma_regs.sv */
// dma register block
`default_nettype none

`include "dma_settings.svh"

module dma_regs (
    input  wire                    hclk,
    input  wire                    rst_n,
    input  wire dma_pkg::reg_req_t reg_req,
    input  wire                    reg_req_valid,
    output logic                   reg_req_ready,
    output logic [`REG_DW-1:0]     reg_rdata,
    output logic                   reg_rsp_valid,
    input  wire                    reg_rsp_ready,
    output dma_pkg::xfer_cfg_t     cfg,
    output logic                   start,
    input  wire                    busy,
    input  wire                    finish
);
    import dma_pkg::*;

    logic [`REG_DW-`ADDR_SHIFT-1:0] addr_q;  // unit address
    logic [`REG_DW-1:0]             lba_q;
    logic [`CNT_W-1:0]              count_q;
    dma_dir_t                       dir_q;
    logic                           done_q;  // sticky completion
    logic                           rsp_valid_q;
    logic [`REG_DW-1:0]             rdata_q;
    logic [`REG_DW-1:0]             rd_mux;
    logic                           req_fire;
    logic                           ctrl_wr;

    assign reg_req_ready = ~rsp_valid_q;     // one read in flight at most
    assign req_fire      = reg_req_valid & reg_req_ready;
    assign ctrl_wr       = req_fire & reg_req.write & (reg_req.offset == `REG_CTRL);
    assign start         = ctrl_wr & reg_req.wdata[`CTRL_START_BIT] & ~busy;

    // dir written together with start must reach the sequencer on the same edge
    assign cfg.dir   = ctrl_wr ? dma_dir_t'(reg_req.wdata[`CTRL_DIR_BIT]) : dir_q;
    assign cfg.addr  = addr_q;
    assign cfg.lba   = lba_q;
    assign cfg.count = count_q;

    assign reg_rsp_valid = rsp_valid_q;
    assign reg_rdata     = rdata_q;

    always_comb begin
        rd_mux = '0;                         // unused offsets read zero
        case (reg_req.offset)
            `REG_ADDR:   rd_mux[`REG_DW-`ADDR_SHIFT-1:0] = addr_q;
            `REG_LBA:    rd_mux = lba_q;
            `REG_COUNT:  rd_mux[`CNT_W-1:0] = count_q;
            `REG_CTRL:   rd_mux[`CTRL_DIR_BIT] = dir_q; // start reads back 0
            `REG_STATUS: begin
                rd_mux[`STAT_BUSY_BIT] = busy;
                rd_mux[`STAT_DONE_BIT] = done_q;
            end
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            addr_q      <= '0;
            lba_q       <= '0;
            count_q     <= '0;
            dir_q       <= DIR_DEV_TO_MEM;
            done_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (req_fire && reg_req.write) begin
                case (reg_req.offset)
                    `REG_ADDR:  addr_q  <= reg_req.wdata[`REG_DW-`ADDR_SHIFT-1:0];
                    `REG_LBA:   lba_q   <= reg_req.wdata;
                    `REG_COUNT: count_q <= reg_req.wdata[`CNT_W-1:0];
                    `REG_CTRL:  dir_q   <= dma_dir_t'(reg_req.wdata[`CTRL_DIR_BIT]);
                    default:    ;                    // status and spare are read only
                endcase
            end
            if (start)
                done_q <= 1'b0;                      // new transfer clears done
            else if (finish)
                done_q <= 1'b1;
            if (req_fire && !reg_req.write)
                rsp_valid_q <= 1'b1;
            else if (reg_rsp_ready)
                rsp_valid_q <= 1'b0;                 // response taken
        end
    end

    // read data, held while the response waits
    always_ff @(posedge hclk) begin
        if (req_fire && !reg_req.write)
            rdata_q <= rd_mux;
    end

endmodule

`default_nettype wire

/* source/sata_dma_top.sv */
// disk to memory dma top level
`default_nettype none

`include "dma_settings.svh"

module sata_dma_top (
    input  wire                    hclk,
    input  wire                    rst_n,
    input  wire dma_pkg::reg_req_t reg_req,
    input  wire                    reg_req_valid,
    output logic                   reg_req_ready,
    output logic [`REG_DW-1:0]     reg_rdata,
    output logic                   reg_rsp_valid,
    input  wire                    reg_rsp_ready,
    output dma_pkg::host_cmd_t     host_cmd,
    output logic                   host_cmd_valid,
    input  wire                    host_cmd_ready,
    output dma_pkg::mem_cmd_t      mem_cmd,
    output logic                   mem_cmd_valid,
    input  wire                    mem_cmd_ready,
    input  wire  [`HOST_DW-1:0]    host_rx_data,
    input  wire                    host_rx_valid,
    output logic                   host_rx_ready,
    output logic [`HOST_DW-1:0]    host_tx_data,
    output logic                   host_tx_valid,
    input  wire                    host_tx_ready,
    output logic [`MEM_DW-1:0]     mem_wr_data,
    output logic                   mem_wr_valid,
    input  wire                    mem_wr_ready,
    input  wire  [`MEM_DW-1:0]     mem_rd_data,
    input  wire                    mem_rd_valid,
    output logic                   mem_rd_ready
);
    import dma_pkg::*;

    xfer_cfg_t cfg;
    logic      start, busy, finish;
    logic      rx_en, rd_en;                    // path enables from sequencer
    logic      pk_in_valid, pk_in_ready, pk_out_valid, pk_out_ready;
    logic      up_in_valid, up_in_ready, up_out_valid, up_out_ready;
    logic      mem_wr_fire, host_tx_fire;

    // device to memory path, closed outside the transfer
    assign pk_in_valid   = host_rx_valid & rx_en;
    assign host_rx_ready = pk_in_ready & rx_en;
    assign mem_wr_valid  = pk_out_valid & rx_en;
    assign pk_out_ready  = mem_wr_ready & rx_en;

    // memory to device path
    assign up_in_valid   = mem_rd_valid & rd_en;
    assign mem_rd_ready  = up_in_ready & rd_en;
    assign host_tx_valid = up_out_valid & rd_en;
    assign up_out_ready  = host_tx_ready & rd_en;

    assign mem_wr_fire  = mem_wr_valid & mem_wr_ready;   // far end, dev to mem
    assign host_tx_fire = host_tx_valid & host_tx_ready; // far end, mem to dev

    dma_regs u_regs (
        .hclk, .rst_n, .reg_req, .reg_req_valid, .reg_req_ready,
        .reg_rdata, .reg_rsp_valid, .reg_rsp_ready,
        .cfg, .start, .busy, .finish
    );

    dma_control u_control (
        .hclk, .rst_n, .cfg, .start, .busy, .finish,
        .host_cmd, .host_cmd_valid, .host_cmd_ready,
        .mem_cmd, .mem_cmd_valid, .mem_cmd_ready,
        .rx_en, .rd_en, .mem_wr_fire, .host_tx_fire
    );

    width_pack u_pack (
        .hclk, .rst_n,
        .in_data  (host_rx_data), .in_valid  (pk_in_valid),  .in_ready  (pk_in_ready),
        .out_data (mem_wr_data),  .out_valid (pk_out_valid), .out_ready (pk_out_ready)
    );

    width_unpack u_unpack (
        .hclk, .rst_n,
        .in_data  (mem_rd_data),  .in_valid  (up_in_valid),  .in_ready  (up_in_ready),
        .out_data (host_tx_data), .out_valid (up_out_valid), .out_ready (up_out_ready)
    );

endmodule

`default_nettype wire

/* source/width_pack.sv */
// 32 to 64 bit packer
`default_nettype none

`include "dma_settings.svh"

module width_pack (
    input  wire                  hclk,
    input  wire                  rst_n,
    input  wire  [`HOST_DW-1:0]  in_data,
    input  wire                  in_valid,
    output logic                 in_ready,
    output logic [`MEM_DW-1:0]   out_data,
    output logic                 out_valid,
    input  wire                  out_ready
);

    logic [`HOST_DW-1:0] lo_q;       // first dword of the pair
    logic                phase_q;    // 1 once low half is held
    logic [`MEM_DW-1:0]  buf_q;      // output word
    logic                buf_full_q;
    logic                in_fire;
    logic                out_fire;
    logic                load;

    // stall only when the buffer is full and not draining
    assign in_ready  = ~buf_full_q | out_ready;
    assign in_fire   = in_valid & in_ready;
    assign out_fire  = buf_full_q & out_ready;
    assign load      = in_fire & phase_q;     // second dword completes a word
    assign out_valid = buf_full_q;
    assign out_data  = buf_q;

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            phase_q    <= 1'b0;
            buf_full_q <= 1'b0;
        end else begin
            if (in_fire)
                phase_q <= ~phase_q;
            if (load)
                buf_full_q <= 1'b1;           // refill wins over drain
            else if (out_fire)
                buf_full_q <= 1'b0;
        end
    end

    always_ff @(posedge hclk) begin
        if (in_fire && !phase_q)
            lo_q <= in_data;
        if (load)
            buf_q <= {in_data, lo_q};         // first dword in low half
    end

endmodule

`default_nettype wire

/* source/width_unpack.sv */
// 64 to 32 bit unpacker
`default_nettype none

`include "dma_settings.svh"

module width_unpack (
    input  wire                  hclk,
    input  wire                  rst_n,
    input  wire  [`MEM_DW-1:0]   in_data,
    input  wire                  in_valid,
    output logic                 in_ready,
    output logic [`HOST_DW-1:0]  out_data,
    output logic                 out_valid,
    input  wire                  out_ready
);

    logic [`MEM_DW-1:0] word_q;     // current memory word
    logic               full_q;     // word held
    logic               half_q;     // 0 low dword next, 1 high
    logic               in_fire;
    logic               out_fire;

    assign in_ready  = ~full_q;      // next word only once emptied
    assign in_fire   = in_valid & in_ready;
    assign out_fire  = full_q & out_ready;
    assign out_valid = full_q;
    assign out_data  = half_q ? word_q[`MEM_DW-1:`HOST_DW] : word_q[`HOST_DW-1:0];

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            half_q <= 1'b0;
        end else if (in_fire) begin
            full_q <= 1'b1;
            half_q <= 1'b0;          // low half first
        end else if (out_fire) begin
            half_q <= ~half_q;
            if (half_q)
                full_q <= 1'b0;      // high dword gone
        end
    end

    always_ff @(posedge hclk) begin
        if (in_fire)
            word_q <= in_data;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
source/dma_pkg.sv
source/dma_regs.sv
source/dma_control.sv
source/width_pack.sv
source/width_unpack.sv
source/sata_dma_top.sv
test/tb_sata_dma.sv

/* test/tb_sata_dma.sv */
// dma engine testbench
`default_nettype none

`include "dma_settings.svh"

module tb_sata_dma;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int NUM_XFER = 6;

    logic hclk, rst_n;
    reg_req_t reg_req;
    logic reg_req_valid, reg_req_ready, reg_rsp_valid, reg_rsp_ready;
    logic [`REG_DW-1:0] reg_rdata;
    host_cmd_t host_cmd;
    mem_cmd_t mem_cmd;
    logic host_cmd_valid, host_cmd_ready, mem_cmd_valid, mem_cmd_ready;
    logic [`HOST_DW-1:0] host_rx_data, host_tx_data;
    logic host_rx_valid, host_rx_ready, host_tx_valid, host_tx_ready;
    logic [`MEM_DW-1:0] mem_wr_data, mem_rd_data;
    logic mem_wr_valid, mem_wr_ready, mem_rd_valid, mem_rd_ready;

    logic [31:0] lfsr = 32'hf093_4e41;            // fixed seed
    int cycles = 0;
    int cycle_limit = 2000;
    logic [`MEM_DW-1:0] data_pool[$];             // all transfer data, drawn up front
    logic [`HOST_DW-1:0] rx_q[$];                 // dwords still to send on host_rx
    logic [`MEM_DW-1:0] rd_q[$];                  // words still to send on mem_rd
    logic [`MEM_DW-1:0] exp_wr_q[$];              // expected mem_wr words
    logic [`HOST_DW-1:0] exp_tx_q[$];             // expected host_tx dwords
    logic rx_fired, rd_fired;                     // source handshake seen this cycle
    int host_cmd_cnt, mem_cmd_cnt;
    host_cmd_t exp_host_cmd;
    mem_cmd_t exp_mem_cmd;
    logic x_dir[NUM_XFER];
    logic [`CNT_W-1:0] x_cnt[NUM_XFER];
    logic [`REG_DW-`ADDR_SHIFT-1:0] x_addr[NUM_XFER];
    logic [`REG_DW-1:0] x_lba[NUM_XFER];
    logic [`REG_DW-`ADDR_SHIFT-1:0] r_addr;       // register readback values
    logic [`REG_DW-1:0] r_lba, rd_val;
    logic [`CNT_W-1:0] r_cnt;
    int beats;

    sata_dma_top dut (.*);

    initial begin
        hclk = 1'b0;
        forever #20 hclk = ~hclk;                 // 40 ns period
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic logic coin();
        return |take_bits(2);                     // high three times in four
    endfunction

    task automatic fail_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("error: %s got %h expected %h", name, got, expected);
            fail_run("value mismatch");
        end
    endtask

    always @(posedge hclk) begin
        cycles++;
        if (cycles > cycle_limit)
            fail_run("timeout: the run did not finish within the cycle limit");
    end

    // host and memory models, inputs change on the falling edge
    task automatic drive_models();
        host_cmd_ready = coin();
        mem_cmd_ready  = coin();
        host_tx_ready  = coin();
        mem_wr_ready   = coin();
        if (rx_fired) host_rx_valid = 1'b0;       // item taken, move on
        if (rd_fired) mem_rd_valid = 1'b0;
        rx_fired = 1'b0;
        rd_fired = 1'b0;
        if (!host_rx_valid && rx_q.size() > 0 && coin()) begin
            host_rx_valid = 1'b1;
            host_rx_data  = rx_q[0];
        end
        if (!mem_rd_valid && rd_q.size() > 0 && coin()) begin
            mem_rd_valid = 1'b1;
            mem_rd_data  = rd_q[0];
        end
    endtask

    // sampled mid cycle, these are the handshakes of the next rising edge
    task automatic observe_models();
        if (host_rx_valid && host_rx_ready) begin
            void'(rx_q.pop_front());
            rx_fired = 1'b1;
        end
        if (mem_rd_valid && mem_rd_ready) begin
            void'(rd_q.pop_front());
            rd_fired = 1'b1;
        end
        if (host_cmd_valid && host_cmd_ready) begin
            check_value("host_cmd", 64'(host_cmd), 64'(exp_host_cmd));
            host_cmd_cnt++;
        end
        if (mem_cmd_valid && mem_cmd_ready) begin
            check_value("mem_cmd", 64'(mem_cmd), 64'(exp_mem_cmd));
            mem_cmd_cnt++;
        end
        if (mem_wr_valid && mem_wr_ready) begin
            if (exp_wr_q.size() == 0) fail_run("memory write beyond the expected data");
            else check_value("mem_wr_data", mem_wr_data, exp_wr_q.pop_front());
        end
        if (host_tx_valid && host_tx_ready) begin
            if (exp_tx_q.size() == 0) fail_run("host transmit beyond the expected data");
            else check_value("host_tx_data", 64'(host_tx_data), 64'(exp_tx_q.pop_front()));
        end
    endtask

    initial begin
        wait (rst_n);
        forever begin
            @(negedge hclk);
            drive_models();
            #5;
            observe_models();
        end
    end

    task automatic reg_write(input logic [`REG_AW-1:0] off, input logic [`REG_DW-1:0] data);
        @(negedge hclk);
        reg_req.write  = 1'b1;
        reg_req.offset = off;
        reg_req.wdata  = data;
        reg_req_valid  = 1'b1;
        #5;
        while (!reg_req_ready) begin
            @(negedge hclk);
            #5;
        end
        @(negedge hclk);
        reg_req_valid = 1'b0;
    endtask

    // stall holds the response for that many cycles before taking it
    task automatic reg_read(input logic [`REG_AW-1:0] off, input int stall,
                            output logic [`REG_DW-1:0] data);
        @(negedge hclk);
        reg_req.write  = 1'b0;
        reg_req.offset = off;
        reg_req.wdata  = '0;
        reg_req_valid  = 1'b1;
        #5;
        while (!reg_req_ready) begin
            @(negedge hclk);
            #5;
        end
        @(negedge hclk);
        reg_req_valid = 1'b0;
        #5;
        while (!reg_rsp_valid) begin
            @(negedge hclk);
            #5;
        end
        data = reg_rdata;
        repeat (stall) begin
            @(negedge hclk);
            #5;
            check_value("reg_rsp_valid", 64'(reg_rsp_valid), 64'(1));
            check_value("reg_rdata", 64'(reg_rdata), 64'(data));
        end
        @(negedge hclk);
        reg_rsp_ready = 1'b1;
        @(negedge hclk);
        reg_rsp_ready = 1'b0;
    endtask

    task automatic run_transfer(input int i);
        logic [`MEM_DW-1:0] w;
        logic [`REG_DW-1:0] ctrl, st;
        int words;
        words = int'(x_cnt[i]) * 64;              // memory words per transfer
        check_value("host_cmd count", 64'(host_cmd_cnt), 64'(i));
        check_value("mem_cmd count", 64'(mem_cmd_cnt), 64'(i));
        exp_host_cmd.dir   = dma_dir_t'(x_dir[i]);
        exp_host_cmd.lba   = x_lba[i];
        exp_host_cmd.count = x_cnt[i];
        exp_mem_cmd.dir    = dma_dir_t'(x_dir[i]);
        exp_mem_cmd.addr   = x_addr[i];
        exp_mem_cmd.words  = 14'(words);
        @(posedge hclk);                          // models idle here
        for (int k = 0; k < words; k++) begin
            w = data_pool.pop_front();
            if (x_dir[i] == 1'b0) begin
                rx_q.push_back(w[31:0]);          // first dword sent ends in low half
                rx_q.push_back(w[63:32]);
                exp_wr_q.push_back(w);
            end else begin
                rd_q.push_back(w);
                exp_tx_q.push_back(w[31:0]);      // low half leaves first
                exp_tx_q.push_back(w[63:32]);
            end
        end
        ctrl = '0;
        ctrl[`CTRL_START_BIT] = 1'b1;
        ctrl[`CTRL_DIR_BIT]   = x_dir[i];
        reg_write(`REG_ADDR, 32'(x_addr[i]));
        reg_write(`REG_LBA, x_lba[i]);
        reg_write(`REG_COUNT, 32'(x_cnt[i]));
        reg_write(`REG_CTRL, ctrl);
        reg_read(`REG_STATUS, 0, st);
        check_value("status", 64'(st), 64'(1 << `STAT_BUSY_BIT)); // done cleared by start
        reg_write(`REG_CTRL, ctrl);               // start while busy, ignored
        do reg_read(`REG_STATUS, 0, st); while (!st[`STAT_DONE_BIT]);
        check_value("status", 64'(st), 64'(1 << `STAT_DONE_BIT));
        check_value("host_cmd count", 64'(host_cmd_cnt), 64'(i + 1));
        check_value("mem_cmd count", 64'(mem_cmd_cnt), 64'(i + 1));
        check_value("mem_wr words left", 64'(exp_wr_q.size()), 64'(0));
        check_value("host_tx dwords left", 64'(exp_tx_q.size()), 64'(0));
        check_value("host_rx dwords left", 64'(rx_q.size()), 64'(0));
        check_value("mem_rd words left", 64'(rd_q.size()), 64'(0));
    endtask

    initial begin
        rst_n = 1'b0;
        reg_req = '0;
        reg_req_valid = 1'b0;
        reg_rsp_ready = 1'b0;
        host_cmd_ready = 1'b0;
        mem_cmd_ready = 1'b0;
        host_rx_data = '0;
        host_rx_valid = 1'b0;
        host_tx_ready = 1'b0;
        mem_wr_ready = 1'b0;
        mem_rd_data = '0;
        mem_rd_valid = 1'b0;
        rx_fired = 1'b0;
        rd_fired = 1'b0;
        host_cmd_cnt = 0;
        mem_cmd_cnt = 0;
        beats = 0;
        r_addr = 25'(take_bits(25));
        r_lba  = take_bits(32);
        r_cnt  = 8'(take_bits(8));
        for (int i = 0; i < NUM_XFER; i++) begin
            x_dir[i]  = (i < 2) ? i[0] : take_bits(1) != 0; // both directions first
            x_cnt[i]  = 8'((take_bits(2) % 3) + 1);
            x_addr[i] = 25'(take_bits(25));
            x_lba[i]  = take_bits(32);
            for (int k = 0; k < int'(x_cnt[i]) * 64; k++)
                data_pool.push_back({take_bits(32), take_bits(32)});
            beats += int'(x_cnt[i]) * 192;        // 64 words plus 128 dwords per sector
        end
        cycle_limit = 4 * beats + 2000;
        repeat (2) @(posedge hclk);
        @(negedge hclk);
        rst_n = 1'b1;

        reg_write(`REG_ADDR, 32'(r_addr));
        reg_write(`REG_LBA, r_lba);
        reg_write(`REG_COUNT, 32'(r_cnt));
        reg_read(`REG_ADDR, 3, rd_val);
        check_value("reg addr", 64'(rd_val), 64'(r_addr));
        reg_read(`REG_LBA, 2, rd_val);
        check_value("reg lba", 64'(rd_val), 64'(r_lba));
        reg_read(`REG_COUNT, 1, rd_val);
        check_value("reg count", 64'(rd_val), 64'(r_cnt));
        for (int off = 5; off < 8; off++) begin
            reg_read(3'(off), 1, rd_val);
            check_value("reg unused", 64'(rd_val), 64'(0));
        end

        for (int i = 0; i < NUM_XFER; i++)
            run_transfer(i);
        repeat (10) @(negedge hclk);              // late duplicate command would show here
        check_value("host_cmd count", 64'(host_cmd_cnt), 64'(NUM_XFER));
        check_value("mem_cmd count", 64'(mem_cmd_cnt), 64'(NUM_XFER));
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
